// File: src/rgmii_pkg.sv
/* RGMII loopback test package
   Widths, frame constants, FSM state types and the CRC-32 byte step */
package rgmii_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [3:0] nibble_t;
	// Data lanes 0 to 3, control lane on top
	typedef logic [4:0] lane_bits_t;
	typedef logic [10:0] len_t;
	typedef logic [15:0] count_t;
	typedef logic [31:0] crc_t;

	typedef enum logic [2:0] {
		GEN_IDLE,
		GEN_PREAMBLE,
		GEN_SFD,
		GEN_PAYLOAD,
		GEN_FCS
	} gen_state_t;

	typedef enum logic [1:0] {
		CHK_HUNT,
		CHK_PREAMBLE,
		CHK_DATA
	} chk_state_t;

	localparam int NUM_LANES = 5;
	localparam int CTL_LANE = NUM_LANES - 1;
	localparam len_t PREAMBLE_LEN = 11'd7;
	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE = 8'hD5;
	localparam crc_t CRC_INIT = 32'hFFFF_FFFF;
	// Reflected form of the Ethernet polynomial 0x04C11DB7
	localparam crc_t CRC_POLY = 32'hEDB8_8320;
	localparam crc_t CRC_RESIDUE = 32'hC704_DD7B;

	// One byte through the CRC, least significant bit first
	function automatic crc_t crc32_step(crc_t crc, byte_t data);
		crc_t c;
		c = crc;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ data[i]) begin
				c = (c >> 1) ^ CRC_POLY;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

endpackage

// File: src/frame_gen.sv
/* Test frame generator
   Sends preamble, SFD, a counting payload from a seed and the CRC-32 FCS,
   each byte split into RGMII rising and falling halves per lane */
module frame_gen (
	input  logic                  tx_clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  rgmii_pkg::len_t       payload_len,
	input  rgmii_pkg::byte_t      seed,
	output logic                  busy,
	output rgmii_pkg::lane_bits_t tx_rise,
	output rgmii_pkg::lane_bits_t tx_fall
);

	// State names the byte currently on tx_rise and tx_fall
	rgmii_pkg::gen_state_t state;
	rgmii_pkg::gen_state_t state_nx;
	rgmii_pkg::len_t idx;
	rgmii_pkg::len_t idx_nx;
	rgmii_pkg::len_t idx_inc;
	rgmii_pkg::len_t len_q;
	rgmii_pkg::byte_t seed_q;
	rgmii_pkg::crc_t crc;
	rgmii_pkg::crc_t crc_nx;
	rgmii_pkg::byte_t byte_nx;
	logic en_nx;

	assign idx_inc = idx + 1'b1;
	assign busy = (state != rgmii_pkg::GEN_IDLE);

	always_comb begin
		state_nx = state;
		idx_nx = idx;
		crc_nx = crc;
		byte_nx = '0;
		en_nx = 1'b0;
		case (state)
		rgmii_pkg::GEN_IDLE: begin
			if (start) begin
				state_nx = rgmii_pkg::GEN_PREAMBLE;
				idx_nx = '0;
				byte_nx = rgmii_pkg::PREAMBLE_BYTE;
				en_nx = 1'b1;
			end
		end
		rgmii_pkg::GEN_PREAMBLE: begin
			en_nx = 1'b1;
			if (idx_inc < rgmii_pkg::PREAMBLE_LEN) begin
				idx_nx = idx_inc;
				byte_nx = rgmii_pkg::PREAMBLE_BYTE;
			end else begin
				state_nx = rgmii_pkg::GEN_SFD;
				byte_nx = rgmii_pkg::SFD_BYTE;
			end
		end
		rgmii_pkg::GEN_SFD: begin
			// First payload byte is the seed itself
			state_nx = rgmii_pkg::GEN_PAYLOAD;
			idx_nx = '0;
			byte_nx = seed_q;
			en_nx = 1'b1;
			crc_nx = rgmii_pkg::crc32_step(rgmii_pkg::CRC_INIT, seed_q);
		end
		rgmii_pkg::GEN_PAYLOAD: begin
			en_nx = 1'b1;
			if (idx_inc < len_q) begin
				idx_nx = idx_inc;
				byte_nx = seed_q + idx_inc[7:0];
				crc_nx = rgmii_pkg::crc32_step(crc, byte_nx);
			end else begin
				// CRC already covers the last payload byte
				state_nx = rgmii_pkg::GEN_FCS;
				idx_nx = '0;
				byte_nx = ~crc[7:0];
			end
		end
		rgmii_pkg::GEN_FCS: begin
			if (idx[1:0] != 2'd3) begin
				idx_nx = idx_inc;
				byte_nx = ~crc[{idx_inc[1:0], 3'b000} +: 8];
				en_nx = 1'b1;
			end else begin
				state_nx = rgmii_pkg::GEN_IDLE;
				idx_nx = '0;
			end
		end
		default: begin
			state_nx = rgmii_pkg::GEN_IDLE;
		end
		endcase
	end

	// tx_er is never raised here, so the falling control half equals tx_en
	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= rgmii_pkg::GEN_IDLE;
			idx <= '0;
			tx_rise <= '0;
			tx_fall <= '0;
		end else begin
			state <= state_nx;
			idx <= idx_nx;
			tx_rise <= {en_nx, byte_nx[3:0]};
			tx_fall <= {en_nx, byte_nx[7:4]};
		end
	end

	always_ff @(posedge tx_clk) begin
		crc <= crc_nx;
		// Frame settings held for the whole frame
		if (!busy && start) begin
			len_q <= payload_len;
			seed_q <= seed;
		end
	end

	a_ctl_in_frame: assert property (@(posedge tx_clk) disable iff (!rst_n)
		tx_rise[rgmii_pkg::CTL_LANE] |-> busy)
		else $error("tx_en high outside a frame");

	// A new frame always starts from the first preamble byte
	a_start_ignored: assert property (@(posedge tx_clk) disable iff (!rst_n)
		(start && busy) |=> !(state == rgmii_pkg::GEN_PREAMBLE && idx == '0))
		else $error("start acted on while busy");

endmodule

// File: src/ddr_lane.sv
/* One RGMII bit lane
   DDR output from rise and fall bits, DDR capture realigned to the rising edge */
module ddr_lane (
	input  logic tx_clk,
	input  logic rst_n,
	input  logic rise_in,
	input  logic fall_in,
	input  logic pin_in,
	output logic pin_out,
	output logic rise_out,
	output logic fall_out
);

	logic rise_q;
	logic fall_d;
	logic fall_q;
	logic rise_cap;
	logic fall_cap;

	// Output side, both halves of a byte taken on the rising edge
	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			rise_q <= 1'b0;
			fall_d <= 1'b0;
		end else begin
			rise_q <= rise_in;
			fall_d <= fall_in;
		end
	end

	// Fall half moves to the low phase of the same cycle
	always_ff @(negedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			fall_q <= 1'b0;
		end else begin
			fall_q <= fall_d;
		end
	end

	// High phase carries the rise bit, low phase the fall bit
	assign pin_out = tx_clk ? rise_q : fall_q;

	// Input side, one sample per edge
	always_ff @(negedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			fall_cap <= 1'b0;
		end else begin
			fall_cap <= pin_in;
		end
	end

	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			rise_cap <= 1'b0;
			rise_out <= 1'b0;
			fall_out <= 1'b0;
		end else begin
			rise_cap <= pin_in;
			// Pair presented together after the next rising edge
			rise_out <= rise_cap;
			fall_out <= fall_cap;
		end
	end

endmodule

// File: src/frame_check.sv
/* Received frame checker
   Rebuilds GMII bytes from the lanes, strips the preamble, checks SFD, rx_er
   and the CRC residue, and counts good and bad frames */
module frame_check (
	input  logic                  tx_clk,
	input  logic                  rst_n,
	input  rgmii_pkg::lane_bits_t rx_rise,
	input  rgmii_pkg::lane_bits_t rx_fall,
	output logic                  frame_done,
	output rgmii_pkg::count_t     good_frames,
	output rgmii_pkg::count_t     bad_frames
);

	rgmii_pkg::chk_state_t state;
	rgmii_pkg::byte_t rx_byte;
	rgmii_pkg::crc_t crc;
	rgmii_pkg::crc_t crc_rev;
	logic rx_dv;
	logic rx_er;
	logic er_seen;
	logic sfd_bad;
	// Bytes after the SFD, saturating at 5
	logic [2:0] data_cnt;
	logic frame_ok;

	assign rx_dv = rx_rise[rgmii_pkg::CTL_LANE];
	assign rx_er = rx_rise[rgmii_pkg::CTL_LANE] ^ rx_fall[rgmii_pkg::CTL_LANE];
	assign rx_byte = {rx_fall[3:0], rx_rise[3:0]};

	// The register runs reflected, the residue constant is in normal bit order
	assign crc_rev = {<<{crc}};

	assign frame_ok = (crc_rev == rgmii_pkg::CRC_RESIDUE) && !er_seen && !sfd_bad &&
		(data_cnt == 3'd5);

	// CRC restarts outside the data phase, so the SFD edge leaves it at init
	always_ff @(posedge tx_clk) begin
		if (state != rgmii_pkg::CHK_DATA) begin
			crc <= rgmii_pkg::CRC_INIT;
		end else if (rx_dv) begin
			crc <= rgmii_pkg::crc32_step(crc, rx_byte);
		end
	end

	always_ff @(posedge tx_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= rgmii_pkg::CHK_HUNT;
			er_seen <= 1'b0;
			sfd_bad <= 1'b0;
			data_cnt <= '0;
			frame_done <= 1'b0;
			good_frames <= '0;
			bad_frames <= '0;
		end else begin
			frame_done <= 1'b0;
			case (state)
			rgmii_pkg::CHK_HUNT: begin
				er_seen <= rx_dv & rx_er;
				sfd_bad <= 1'b0;
				data_cnt <= '0;
				if (rx_dv) begin
					// Preamble may be short or missing entirely
					if (rx_byte == rgmii_pkg::PREAMBLE_BYTE) begin
						state <= rgmii_pkg::CHK_PREAMBLE;
					end else begin
						state <= rgmii_pkg::CHK_DATA;
						sfd_bad <= (rx_byte != rgmii_pkg::SFD_BYTE);
					end
				end
			end
			rgmii_pkg::CHK_PREAMBLE: begin
				if (!rx_dv) begin
					// Ended before any SFD
					state <= rgmii_pkg::CHK_HUNT;
					frame_done <= 1'b1;
					bad_frames <= bad_frames + 1'b1;
				end else begin
					er_seen <= er_seen | rx_er;
					if (rx_byte != rgmii_pkg::PREAMBLE_BYTE) begin
						state <= rgmii_pkg::CHK_DATA;
						sfd_bad <= (rx_byte != rgmii_pkg::SFD_BYTE);
					end
				end
			end
			rgmii_pkg::CHK_DATA: begin
				if (rx_dv) begin
					er_seen <= er_seen | rx_er;
					if (data_cnt != 3'd5) begin
						data_cnt <= data_cnt + 1'b1;
					end
				end else begin
					state <= rgmii_pkg::CHK_HUNT;
					frame_done <= 1'b1;
					if (frame_ok) begin
						good_frames <= good_frames + 1'b1;
					end else begin
						bad_frames <= bad_frames + 1'b1;
					end
				end
			end
			default: begin
				state <= rgmii_pkg::CHK_HUNT;
			end
			endcase
		end
	end

	a_one_verdict: assert property (@(posedge tx_clk) disable iff (!rst_n)
		!($changed(good_frames) && $changed(bad_frames)))
		else $error("good and bad counters moved together");

endmodule

// File: src/rgmii_hw_test.sv
/* RGMII loopback hardware test top level
   Frame generator, five DDR lanes and frame checker on one clock */
module rgmii_hw_test (
	input  logic                     tx_clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  rgmii_pkg::len_t          payload_len,
	input  rgmii_pkg::byte_t         seed,
	input  rgmii_pkg::nibble_t       rgmii_rxd,
	input  logic                     rgmii_rx_ctl,
	output rgmii_pkg::nibble_t       rgmii_txd,
	output logic                     rgmii_tx_ctl,
	output logic                     rgmii_tx_clk,
	output logic                     busy,
	output logic                     frame_done,
	output rgmii_pkg::count_t        good_frames,
	output rgmii_pkg::count_t        bad_frames
);

	rgmii_pkg::lane_bits_t tx_rise;
	rgmii_pkg::lane_bits_t tx_fall;
	rgmii_pkg::lane_bits_t rx_rise;
	rgmii_pkg::lane_bits_t rx_fall;
	rgmii_pkg::lane_bits_t pins_out;
	rgmii_pkg::lane_bits_t pins_in;

	// Control lane sits above the four data lanes
	assign pins_in = {rgmii_rx_ctl, rgmii_rxd};
	assign {rgmii_tx_ctl, rgmii_txd} = pins_out;
	assign rgmii_tx_clk = tx_clk;

	frame_gen i_frame_gen (
		.tx_clk      (tx_clk),
		.rst_n       (rst_n),
		.start       (start),
		.payload_len (payload_len),
		.seed        (seed),
		.busy        (busy),
		.tx_rise     (tx_rise),
		.tx_fall     (tx_fall)
	);

	for (genvar k = 0; k < rgmii_pkg::NUM_LANES; k++) begin : g_lane
		ddr_lane i_ddr_lane (
			.tx_clk   (tx_clk),
			.rst_n    (rst_n),
			.rise_in  (tx_rise[k]),
			.fall_in  (tx_fall[k]),
			.pin_in   (pins_in[k]),
			.pin_out  (pins_out[k]),
			.rise_out (rx_rise[k]),
			.fall_out (rx_fall[k])
		);
	end

	frame_check i_frame_check (
		.tx_clk      (tx_clk),
		.rst_n       (rst_n),
		.rx_rise     (rx_rise),
		.rx_fall     (rx_fall),
		.frame_done  (frame_done),
		.good_frames (good_frames),
		.bad_frames  (bad_frames)
	);

endmodule

// File: bench/tb_clock_gen.sv
/* Testbench clock and reset
   20 ns clock, reset held low for the first 3 cycles */
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// File: bench/tb_rgmii_hw_test.sv
/* RGMII loopback testbench
   PHY loopback model with bit-flip and rx_er injection, driven from a vector file */
module tb_rgmii_hw_test;

	timeunit 1ns;
	timeprecision 100ps;

	logic tx_clk;
	logic rst_n;
	logic start;
	rgmii_pkg::len_t payload_len;
	rgmii_pkg::byte_t seed;
	rgmii_pkg::nibble_t rgmii_rxd = '0;
	logic rgmii_rx_ctl = 1'b0;
	rgmii_pkg::nibble_t rgmii_txd;
	logic rgmii_tx_ctl;
	logic rgmii_tx_clk;
	logic busy;
	logic frame_done;
	rgmii_pkg::count_t good_frames;
	rgmii_pkg::count_t bad_frames;

	// Vector table
	int vec_len[$];
	int vec_seed[$];
	int vec_mode[$];
	int vec_good[$];

	int errors = 0;
	int checks = 0;
	int done_count = 0;
	logic [31:0] lfsr = 32'd99415;

	// PHY model state
	int cur_mode = 0;
	int target_byte = 0;
	int flip_bit = 0;
	int byte_idx = 0;
	logic in_frame = 1'b0;
	logic [4:0] rise_hold = '0;
	logic [4:0] fall_hold = '0;

	tb_clock_gen i_tb_clock_gen (
		.clk   (tx_clk),
		.rst_n (rst_n)
	);

	rgmii_hw_test i_rgmii_hw_test (
		.tx_clk       (tx_clk),
		.rst_n        (rst_n),
		.start        (start),
		.payload_len  (payload_len),
		.seed         (seed),
		.rgmii_rxd    (rgmii_rxd),
		.rgmii_rx_ctl (rgmii_rx_ctl),
		.rgmii_txd    (rgmii_txd),
		.rgmii_tx_ctl (rgmii_tx_ctl),
		.rgmii_tx_clk (rgmii_tx_clk),
		.busy         (busy),
		.frame_done   (frame_done),
		.good_frames  (good_frames),
		.bad_frames   (bad_frames)
	);

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic check_count(input string what, input rgmii_pkg::count_t got,
		input rgmii_pkg::count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Rising half: last falling sample goes out for the next falling edge
	always @(posedge tx_clk) begin
		logic [4:0] smp;
		#1;
		{rgmii_rx_ctl, rgmii_rxd} = fall_hold;
		smp = {rgmii_tx_ctl, rgmii_txd};
		if (smp[4]) begin
			byte_idx = in_frame ? byte_idx + 1 : 0;
			in_frame = 1'b1;
		end else begin
			in_frame = 1'b0;
		end
		// Byte 8 is the first one after the SFD
		if (in_frame && byte_idx == 8 + target_byte && cur_mode == 1 && flip_bit < 4) begin
			smp[flip_bit] = ~smp[flip_bit];
		end
		rise_hold = smp;
	end

	// Falling half, same byte as the last rising sample
	// Rising sample goes out for the next rising edge
	always @(negedge tx_clk) begin
		logic [4:0] smp;
		#1;
		{rgmii_rx_ctl, rgmii_rxd} = rise_hold;
		smp = {rgmii_tx_ctl, rgmii_txd};
		if (in_frame && byte_idx == 8 + target_byte) begin
			if (cur_mode == 1 && flip_bit >= 4) begin
				smp[flip_bit - 4] = ~smp[flip_bit - 4];
			end else if (cur_mode == 2) begin
				smp[4] = ~smp[4];
			end
		end
		fall_hold = smp;
	end

	always @(negedge tx_clk) begin
		if (frame_done) begin
			done_count++;
		end
	end

	task automatic load_vectors();
		int fd;
		int code;
		int l;
		int s;
		int m;
		int g;
		string line;
		fd = $fopen("bench/rgmii_vectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open the vector file bench/rgmii_vectors.txt");
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 0 && line[0] != "#") begin
					if ($sscanf(line, "%d %h %d %d", l, s, m, g) == 4) begin
						vec_len.push_back(l);
						vec_seed.push_back(s);
						vec_mode.push_back(m);
						vec_good.push_back(g);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_frame(input int i);
		int busy_cycles;
		int done0;
		int r;
		rgmii_pkg::count_t good0;
		rgmii_pkg::count_t bad0;
		good0 = good_frames;
		bad0 = bad_frames;
		done0 = done_count;
		cur_mode = vec_mode[i];
		take_bits(11, r);
		target_byte = r % (vec_len[i] + 4);
		take_bits(3, flip_bit);
		payload_len = rgmii_pkg::len_t'(vec_len[i]);
		seed = rgmii_pkg::byte_t'(vec_seed[i]);
		start = 1'b1;
		@(negedge tx_clk);
		start = 1'b0;
		busy_cycles = 0;
		while (busy) begin
			busy_cycles++;
			// A second request in mid-frame must be dropped
			start = (busy_cycles == 3);
			@(negedge tx_clk);
		end
		start = 1'b0;
		check_count("busy cycles", rgmii_pkg::count_t'(busy_cycles),
			rgmii_pkg::count_t'(vec_len[i] + 12));
		while (done_count == done0) begin
			@(negedge tx_clk);
		end
		repeat (8) @(negedge tx_clk);
		check_count("frame_done pulses", rgmii_pkg::count_t'(done_count - done0), 16'd1);
		if (vec_good[i] != 0) begin
			check_count("good_frames", good_frames, good0 + 16'd1);
			check_count("bad_frames", bad_frames, bad0);
		end else begin
			check_count("good_frames", good_frames, good0);
			check_count("bad_frames", bad_frames, bad0 + 16'd1);
		end
	endtask

	initial begin
		longint limit_cycles;
		int total_good;
		int total_bad;
		start = 1'b0;
		payload_len = '0;
		seed = '0;
		load_vectors();
		if (vec_len.size() == 0) begin
			errors++;
			$display("No test vectors were read, nothing to run");
		end
		limit_cycles = 500;
		total_good = 0;
		total_bad = 0;
		foreach (vec_len[i]) begin
			limit_cycles += vec_len[i] + 12 + 20;
			if (vec_good[i] != 0) begin
				total_good++;
			end else begin
				total_bad++;
			end
		end
		fork
			begin
				#(limit_cycles * 20);
				$display("watchdog expired before all frames returned");
				$display("TEST RESULT: FAIL");
				$finish;
			end
		join_none
		@(posedge rst_n);
		repeat (2) @(negedge tx_clk);
		check_flag("busy after reset", busy, 1'b0);
		check_flag("rgmii_tx_ctl after reset", rgmii_tx_ctl, 1'b0);
		check_flag("frame_done after reset", frame_done, 1'b0);
		check_count("good_frames after reset", good_frames, 16'd0);
		check_count("bad_frames after reset", bad_frames, 16'd0);
		// Forwarded clock follows tx_clk in both phases
		check_flag("rgmii_tx_clk in low phase", rgmii_tx_clk, 1'b0);
		@(posedge tx_clk);
		#1;
		check_flag("rgmii_tx_clk in high phase", rgmii_tx_clk, 1'b1);
		@(negedge tx_clk);
		foreach (vec_len[i]) begin
			run_frame(i);
		end
		check_count("total good_frames", good_frames, rgmii_pkg::count_t'(total_good));
		check_count("total bad_frames", bad_frames, rgmii_pkg::count_t'(total_bad));
		$display("Frames: %0d, checks: %0d, errors: %0d", vec_len.size(), checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: bench/rgmii_vectors.txt
# payload_len (decimal), seed (hex), mode (0 clean, 1 bit flip, 2 rx_er)
# expected verdict (1 good, 0 bad)
1 00 0 1
46 a5 0 1
1500 3c 0 1
64 ff 0 1
46 10 1 0
1 7e 1 0
200 c3 1 0
46 20 2 0
1 99 2 0
1500 01 1 0
60 42 0 1
128 80 2 0
5 00 0 1
46 f0 0 1

// File: all.f
src/rgmii_pkg.sv
src/frame_gen.sv
src/ddr_lane.sv
src/frame_check.sv
src/rgmii_hw_test.sv
bench/tb_clock_gen.sv
bench/tb_rgmii_hw_test.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_rgmii_hw_test
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and check for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o sim
	./$(OBJDIR)/sim | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
